//--- tb.f
+incdir+verif
hw/rvc_pkg.sv
hw/rvc_q0_expander.sv
hw/rvc_q1_expander.sv
hw/rvc_q2_expander.sv
hw/rvc_expander.sv
verif/rvc_expander_checker.sv
verif/rvc_expander_tb.sv

//--- verif/rvc_ref.svh
`ifndef RVC_REF_SVH
`define RVC_REF_SVH

// rv32i store, branch, jump and register layouts
function automatic inst_t s_type(input logic [11:0] imm, input logic [4:0] rs2, rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
endfunction

function automatic inst_t b_type(input logic [12:0] imm, input logic [4:0] rs1,
                                 input logic [2:0] f3);
    return {imm[12], imm[10:5], REG_ZERO, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic inst_t j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

function automatic inst_t r_type(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                 input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

// x8..x15 from a 3-bit field
function automatic logic [4:0] cr(input logic [2:0] r);
    return {CREG_PREFIX, r};
endfunction

function automatic void enc_addi4spn(input logic [2:0] rd, input logic [9:0] u,
                                     output cinst_t c, output inst_t e);
    c = {3'b000, u[5:4], u[9:6], u[2], u[3], rd, 2'b00};
    e = {2'b00, u, REG_SP, 3'b000, cr(rd), OPC_OP_IMM};
endfunction

function automatic void enc_lw_sw(input logic store, input logic [2:0] rs1, rd,
                                  input logic [6:0] u, output cinst_t c, output inst_t e);
    c = {store, 2'b10, u[5:3], rs1, u[2], u[6], rd, 2'b00};
    if (store) e = s_type({5'b00000, u}, cr(rd), cr(rs1)); // rd field is rs2' here
    else e = {5'b00000, u, cr(rs1), 3'b010, cr(rd), OPC_LOAD};
endfunction

function automatic void enc_sp(input logic store, input logic [4:0] r, input logic [7:0] u,
                               output cinst_t c, output inst_t e);
    if (store) begin
        c = {3'b110, u[5:2], u[7:6], r, 2'b10};
        e = s_type({4'b0000, u}, r, REG_SP);
    end else begin
        c = {3'b010, u[5], r, u[4:2], u[7:6], 2'b10};
        e = {4'b0000, u, REG_SP, 3'b010, r, OPC_LOAD};
    end
endfunction

function automatic void enc_addi_li(input logic li, input logic [4:0] rd, input logic [5:0] i,
                                    output cinst_t c, output inst_t e);
    c = {1'b0, li, 1'b0, i[5], rd, i[4:0], 2'b01};
    e = {{6{i[5]}}, i, li ? REG_ZERO : rd, 3'b000, rd, OPC_OP_IMM};
endfunction

function automatic void enc_lui(input logic [4:0] rd, input logic [5:0] i,
                                output cinst_t c, output inst_t e);
    c = {3'b011, i[5], rd, i[4:0], 2'b01};
    e = {{14{i[5]}}, i, rd, OPC_LUI};
endfunction

function automatic void enc_addi16sp(input logic [9:0] n, output cinst_t c, output inst_t e);
    c = {3'b011, n[9], REG_SP, n[4], n[6], n[8:7], n[5], 2'b01};
    e = {{2{n[9]}}, n, REG_SP, 3'b000, REG_SP, OPC_OP_IMM};
endfunction

// f2 picks srli, srai or andi
function automatic void enc_alu_imm(input logic [1:0] f2, input logic [2:0] rd,
                                    input logic [5:0] i, output cinst_t c, output inst_t e);
    c = {3'b100, i[5], f2, rd, i[4:0], 2'b01};
    if (f2 == 2'b10) e = {{6{i[5]}}, i, cr(rd), 3'b111, cr(rd), OPC_OP_IMM};
    else e = {1'b0, f2[0], 5'b00000, i[4:0], cr(rd), 3'b101, cr(rd), OPC_OP_IMM};
endfunction

function automatic void enc_arith(input logic [1:0] op, input logic [2:0] rd, rs,
                                  output cinst_t c, output inst_t e);
    logic [2:0] f3;
    f3 = (op == 2'b00) ? 3'b000 : {1'b1, op[1], op[1] & op[0]}; // sub, xor, or, and
    c = {6'b100011, rd, op, rs, 2'b01};
    e = r_type({1'b0, op == 2'b00, 5'b00000}, cr(rs), cr(rd), f3, cr(rd));
endfunction

function automatic void enc_jump(input logic link, input logic [11:0] o,
                                 output cinst_t c, output inst_t e);
    c = {link ? 3'b001 : 3'b101, o[11], o[4], o[9:8], o[10], o[6], o[7], o[3:1], o[5], 2'b01};
    e = j_type({{9{o[11]}}, o}, link ? REG_RA : REG_ZERO);
endfunction

function automatic void enc_branch(input logic bnez, input logic [2:0] rs, input logic [8:0] o,
                                   output cinst_t c, output inst_t e);
    c = {2'b11, bnez, o[8], o[4:3], rs, o[7:6], o[2:1], o[5], 2'b01};
    e = b_type({{4{o[8]}}, o}, cr(rs), {2'b00, bnez});
endfunction

function automatic void enc_jr(input logic link, input logic [4:0] rs1,
                               output cinst_t c, output inst_t e);
    c = {3'b100, link, rs1, 5'b00000, 2'b10};
    e = {12'h000, rs1, 3'b000, link ? REG_RA : REG_ZERO, OPC_JALR};
endfunction

function automatic void enc_mv_add(input logic add, input logic [4:0] rd, rs2,
                                   output cinst_t c, output inst_t e);
    c = {3'b100, add, rd, rs2, 2'b10};
    e = r_type(7'b0000000, rs2, add ? rd : REG_ZERO, 3'b000, rd);
endfunction

function automatic void enc_slli(input logic [4:0] rd, sh, output cinst_t c, output inst_t e);
    c = {4'b0000, rd, sh, 2'b10};
    e = {7'b0000000, sh, rd, 3'b001, rd, OPC_OP_IMM};
endfunction

`endif

//--- verif/rvc_expander_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rvc_expander_tb import rvc_pkg::*; ();

    `include "rvc_ref.svh"

    localparam int CLK_PERIOD = 8;
    localparam int REPS       = 4;
    localparam int N_KINDS    = 25;
    localparam int ISSUED     = 160; // all tests together, rounded up

    logic   clk_i = 1'b0;
    logic   rst_i;
    logic   valid_i;
    cinst_t cinst_i;
    logic   valid_o;
    inst_t  inst_o;

    logic [31:0] rng_state = 32'h8a75_99a4;
    string kind_names [N_KINDS] = '{"c.addi4spn", "c.lw", "c.sw", "c.lwsp", "c.swsp",
        "c.addi", "c.li", "c.lui", "c.addi16sp", "c.srli", "c.srai", "c.andi", "c.sub",
        "c.xor", "c.or", "c.and", "c.j", "c.jal", "c.beqz", "c.bnez", "c.jr", "c.jalr",
        "c.slli", "c.mv", "c.add"};

    rvc_expander rvc_expander_inst (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (valid_i),
        .cinst_i (cinst_i),
        .valid_o (valid_o),
        .inst_o  (inst_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    // random legal fields for one kept instruction kind
    function automatic void random_instruction(input int kind, output string name,
                                               output cinst_t c, output inst_t e);
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [7:0]  nz8;
        logic [5:0]  nz6;
        r    = xorshift32();
        rd   = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
        rs   = (r[9:5] == 5'd0) ? 5'd3 : r[9:5];
        nz8  = (r[17:10] == 8'd0) ? 8'h5a : r[17:10];
        nz6  = (r[23:18] == 6'd0) ? 6'h21 : r[23:18];
        name = kind_names[kind];
        case (kind)
            0:  enc_addi4spn(r[2:0], {nz8, 2'b00}, c, e);
            1:  enc_lw_sw(1'b0, r[2:0], r[5:3], {r[14:10], 2'b00}, c, e);
            2:  enc_lw_sw(1'b1, r[2:0], r[5:3], {r[14:10], 2'b00}, c, e);
            3:  enc_sp(1'b0, rd, {r[15:10], 2'b00}, c, e);
            4:  enc_sp(1'b1, r[4:0], {r[15:10], 2'b00}, c, e);
            5:  enc_addi_li(1'b0, rd, r[23:18], c, e);
            6:  enc_addi_li(1'b1, rd, r[23:18], c, e);
            7:  enc_lui((rd == REG_SP) ? 5'd3 : rd, nz6, c, e);
            8:  enc_addi16sp({nz6, 4'b0000}, c, e);
            9:  enc_alu_imm(2'b00, r[2:0], {1'b0, r[22:18]}, c, e);
            10: enc_alu_imm(2'b01, r[2:0], {1'b0, r[22:18]}, c, e);
            11: enc_alu_imm(2'b10, r[2:0], r[23:18], c, e);
            12, 13, 14, 15: enc_arith(2'(kind - 12), r[2:0], r[5:3], c, e);
            16: enc_jump(1'b0, {r[21:11], 1'b0}, c, e);
            17: enc_jump(1'b1, {r[21:11], 1'b0}, c, e);
            18: enc_branch(1'b0, r[2:0], {r[18:11], 1'b0}, c, e);
            19: enc_branch(1'b1, r[2:0], {r[18:11], 1'b0}, c, e);
            20: enc_jr(1'b0, rd, c, e);
            21: enc_jr(1'b1, rd, c, e);
            22: enc_slli(rd, r[9:5], c, e);
            23: enc_mv_add(1'b0, rd, rs, c, e);
            default: enc_mv_add(1'b1, rd, rs, c, e);
        endcase
    endfunction

    task automatic check_inst(input string name, input inst_t got, input inst_t exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s expanded to %h, expected %h", $time, name, got, exp);
            $display("Test FAILED");
            $fatal(1, "wrong expansion");
        end
    endtask

    task automatic check_valid(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s valid_o is %b, expected %b", $time, name, got, exp);
            $display("Test FAILED");
            $fatal(1, "wrong valid flag");
        end
    endtask

    // one pulse, result checked after the capturing edge
    task automatic issue_and_check(input string name, input cinst_t c, input inst_t e);
        @(negedge clk_i);
        valid_i = 1'b1;
        cinst_i = c;
        @(negedge clk_i);
        valid_i = 1'b0;
        check_valid(name, valid_o, 1'b1);
        check_inst(name, inst_o, e);
    endtask

    task automatic test_reset();
        cinst_t c;
        inst_t  e;
        string  name;
        check_valid("after reset", valid_o, 1'b0);
        check_inst("after reset", inst_o, NOP_INST);
        random_instruction(5, name, c, e);
        issue_and_check(name, c, e);
        @(negedge clk_i);
        check_valid("end of pulse", valid_o, 1'b0);
        check_inst("held output", inst_o, e);
    endtask

    task automatic test_kinds(input int first, input int last);
        cinst_t c;
        inst_t  e;
        string  name;
        for (int k = first; k <= last; k++) begin
            repeat (REPS) begin
                random_instruction(k, name, c, e);
                issue_and_check(name, c, e);
            end
        end
    endtask

    task automatic test_unsupported();
        logic [31:0] r;
        for (int f = 0; f < 8; f++) begin
            r = xorshift32();
            if (f[0] || f == 4) issue_and_check("q0 unsupported", {f[2:0], r[10:0], 2'b00},
                                                NOP_INST);
            if (f[0]) issue_and_check("q2 unsupported", {f[2:0], r[10:0], 2'b10}, NOP_INST);
            issue_and_check("q3 word", {r[26:13], 2'b11}, NOP_INST);
        end
    endtask

    task automatic test_stream();
        inst_t  exp_q[$];
        string  name_q[$];
        cinst_t c;
        inst_t  e;
        string  name;
        for (int i = 0; i < 32; i++) begin
            @(negedge clk_i);
            if (i > 0) begin
                check_valid(name_q[0], valid_o, 1'b1);
                check_inst(name_q.pop_front(), inst_o, exp_q.pop_front());
            end
            random_instruction(int'(xorshift32() % N_KINDS), name, c, e);
            valid_i = 1'b1;
            cinst_i = c;
            exp_q.push_back(e);
            name_q.push_back(name);
        end
        @(negedge clk_i);
        valid_i = 1'b0;
        check_valid(name_q[0], valid_o, 1'b1);
        check_inst(name_q.pop_front(), inst_o, exp_q.pop_front());
    endtask

    initial begin
        #(ISSUED * 10 * CLK_PERIOD + 1000);
        $display("timeout: the tests did not finish in time");
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

    // bound assertions count their failures
    initial begin
        wait (rvc_expander_inst.rvc_expander_checker_inst.fail_count != 0);
        $display("ERROR %0t: a checker assertion failed", $time);
        $display("Test FAILED");
        $fatal(1, "assertion failure");
    end

    initial begin
        rst_i   = 1'b1;
        valid_i = 1'b0;
        cinst_i = '0;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        test_reset();
        test_kinds(0, 4);   // q0 and sp loads/stores
        test_kinds(5, 15);  // q1 arithmetic
        test_kinds(16, 21); // control flow
        issue_and_check("c.ebreak", 16'h9002, EBREAK_INST);
        test_kinds(22, 24);
        test_unsupported();
        test_stream();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/rvc_expander_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rvc_expander_checker import rvc_pkg::*; (
    input wire logic   clk_i,
    input wire logic   rst_i,
    input wire logic   valid_i,
    input wire cinst_t cinst_i,
    input wire logic   valid_o,
    input wire inst_t  inst_o
);

    int unsigned fail_count = 0; // failed assertions so far

    a_reset_clears_valid: assert property (@(posedge clk_i) rst_i |=> !valid_o)
        else begin
            $error("valid_o high after reset");
            fail_count++;
        end

    // one cycle latency on the valid flag
    a_valid_latency: assert property (@(posedge clk_i) disable iff (rst_i)
        1'b1 |=> valid_o == $past(valid_i))
        else begin
            $error("valid_o does not follow valid_i");
            fail_count++;
        end

    a_q3_gives_nop: assert property (@(posedge clk_i) disable iff (rst_i)
        (valid_i && cinst_i[1:0] == 2'b11) |=> inst_o == NOP_INST)
        else begin
            $error("uncompressed word not expanded to nop");
            fail_count++;
        end

endmodule

bind rvc_expander rvc_expander_checker rvc_expander_checker_inst (.*);

`default_nettype wire

//--- hw/rvc_expander.sv
`timescale 1ns/1ps
`default_nettype none

module rvc_expander import rvc_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_i,
    input  logic   valid_i,
    input  cinst_t cinst_i,
    output logic   valid_o,
    output inst_t  inst_o
);

    c_quadrant_e quadrant;
    inst_t       inst_q0;
    inst_t       inst_q1;
    inst_t       inst_q2;
    inst_t       inst_next;

    assign quadrant = c_quadrant_e'(cinst_i[1:0]);

    rvc_q0_expander rvc_q0_expander_inst (
        .cinst_i (cinst_i),
        .inst_o  (inst_q0)
    );

    rvc_q1_expander rvc_q1_expander_inst (
        .cinst_i (cinst_i),
        .inst_o  (inst_q1)
    );

    rvc_q2_expander rvc_q2_expander_inst (
        .cinst_i (cinst_i),
        .inst_o  (inst_q2)
    );

    always_comb begin
        case (quadrant)
            Q0:      inst_next = inst_q0;
            Q1:      inst_next = inst_q1;
            Q2:      inst_next = inst_q2;
            default: inst_next = NOP_INST; // full 32-bit word, not ours to expand
        endcase
    end

    // one cycle of latency, a new word accepted every cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
            inst_o  <= NOP_INST;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                inst_o <= inst_next; // holds last result while idle
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/rvc_q2_expander.sv
`timescale 1ns/1ps
`default_nettype none

module rvc_q2_expander import rvc_pkg::*; (
    input  cinst_t cinst_i,
    output inst_t  inst_o
);

    logic [2:0]       funct3;
    logic [REG_W-1:0] rd;          // also rs1 for jr/jalr
    logic [REG_W-1:0] rs2;
    logic [11:0]      lwsp_imm;
    logic [11:0]      swsp_imm;

    assign funct3 = cinst_i[15:13];
    assign rd     = cinst_i[11:7];
    assign rs2    = cinst_i[6:2];

    // offset[5] from bit 12, offset[4:2|7:6] from 6:2
    assign lwsp_imm = {4'b0000, cinst_i[3:2], cinst_i[12], cinst_i[6:4], 2'b00};

    // offset[5:2|7:6] from 12:7
    assign swsp_imm = {4'b0000, cinst_i[8:7], cinst_i[12:9], 2'b00};

    always_comb begin
        inst_o = NOP_INST;
        case (funct3)
            3'b000: begin // c.slli
                inst_o = {7'b0000000, rs2, rd, 3'b001, rd, OPC_OP_IMM};
            end
            3'b010: begin // c.lwsp
                inst_o = {lwsp_imm, REG_SP, 3'b010, rd, OPC_LOAD};
            end
            3'b100: begin
                if (!cinst_i[12]) begin
                    if (rs2 == REG_ZERO) begin
                        inst_o = {12'h000, rd, 3'b000, REG_ZERO, OPC_JALR}; // c.jr
                    end else begin
                        inst_o = {7'b0000000, rs2, REG_ZERO, 3'b000, rd, OPC_OP}; // c.mv
                    end
                end else if (rs2 == REG_ZERO) begin
                    if (rd == REG_ZERO) begin
                        inst_o = EBREAK_INST;
                    end else begin
                        inst_o = {12'h000, rd, 3'b000, REG_RA, OPC_JALR}; // c.jalr
                    end
                end else begin
                    inst_o = {7'b0000000, rs2, rd, 3'b000, rd, OPC_OP}; // c.add
                end
            end
            3'b110: begin // c.swsp
                inst_o = {swsp_imm[11:5], rs2, REG_SP, 3'b010, swsp_imm[4:0], OPC_STORE};
            end
            default: begin
                inst_o = NOP_INST; // fp loads/stores not supported
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/rvc_q1_expander.sv
`timescale 1ns/1ps
`default_nettype none

module rvc_q1_expander import rvc_pkg::*; (
    input  cinst_t cinst_i,
    output inst_t  inst_o
);

    logic [2:0]       funct3;
    logic [REG_W-1:0] rd;           // full rd/rs1 field
    logic [REG_W-1:0] creg_hi;      // rd'/rs1', bits 9:7
    logic [REG_W-1:0] creg_lo;      // rs2', bits 4:2
    logic [11:0]      imm6_sext;    // 6-bit immediate sign extended
    logic [11:0]      addi16sp_imm;
    logic [19:0]      lui_imm;
    logic [19:0]      jal_imm;      // already in jal field order
    logic [6:0]       br_imm_hi;    // imm[12|10:5]
    logic [4:0]       br_imm_lo;    // imm[4:1|11]
    logic [4:0]       shamt;

    assign funct3  = cinst_i[15:13];
    assign rd      = cinst_i[11:7];
    assign creg_hi = {CREG_PREFIX, cinst_i[9:7]};
    assign creg_lo = {CREG_PREFIX, cinst_i[4:2]};
    assign shamt   = cinst_i[6:2];

    assign imm6_sext = {{7{cinst_i[12]}}, cinst_i[6:2]};

    // nzimm[9|4|6|8:7|5] scaled by 16
    assign addi16sp_imm = {{3{cinst_i[12]}}, cinst_i[4:3], cinst_i[5], cinst_i[2], cinst_i[6],
                           4'b0000};

    assign lui_imm = {{15{cinst_i[12]}}, cinst_i[6:2]};

    // offset[11|4|9:8|10|6|7|3:1|5] reordered into imm[20|10:1|11|19:12]
    assign jal_imm = {cinst_i[12], cinst_i[8], cinst_i[10:9], cinst_i[6], cinst_i[7],
                      cinst_i[2], cinst_i[11], cinst_i[5:3], {9{cinst_i[12]}}};

    // offset[8|4:3] from 12:10 and offset[7:6|2:1|5] from 6:2
    assign br_imm_hi = {{4{cinst_i[12]}}, cinst_i[6:5], cinst_i[2]};
    assign br_imm_lo = {cinst_i[11:10], cinst_i[4:3], cinst_i[12]};

    always_comb begin
        inst_o = NOP_INST;
        case (funct3)
            3'b000: begin // c.addi
                inst_o = {imm6_sext, rd, 3'b000, rd, OPC_OP_IMM};
            end
            3'b001: begin // c.jal links through ra
                inst_o = {jal_imm, REG_RA, OPC_JAL};
            end
            3'b010: begin // c.li
                inst_o = {imm6_sext, REG_ZERO, 3'b000, rd, OPC_OP_IMM};
            end
            3'b011: begin
                if (rd == REG_SP) begin
                    inst_o = {addi16sp_imm, REG_SP, 3'b000, REG_SP, OPC_OP_IMM};
                end else begin
                    inst_o = {lui_imm, rd, OPC_LUI};
                end
            end
            3'b100: begin
                case (cinst_i[11:10])
                    2'b00: inst_o = {7'b0000000, shamt, creg_hi, 3'b101, creg_hi, OPC_OP_IMM};
                    2'b01: inst_o = {7'b0100000, shamt, creg_hi, 3'b101, creg_hi, OPC_OP_IMM};
                    2'b10: inst_o = {imm6_sext, creg_hi, 3'b111, creg_hi, OPC_OP_IMM}; // c.andi
                    default: begin
                        // register-register group picked by bits 6:5
                        case (cinst_i[6:5])
                            2'b00: inst_o = {7'b0100000, creg_lo, creg_hi, 3'b000, creg_hi,
                                             OPC_OP};
                            2'b01: inst_o = {7'b0000000, creg_lo, creg_hi, 3'b100, creg_hi,
                                             OPC_OP};
                            2'b10: inst_o = {7'b0000000, creg_lo, creg_hi, 3'b110, creg_hi,
                                             OPC_OP};
                            default: inst_o = {7'b0000000, creg_lo, creg_hi, 3'b111, creg_hi,
                                               OPC_OP};
                        endcase
                    end
                endcase
            end
            3'b101: begin // c.j
                inst_o = {jal_imm, REG_ZERO, OPC_JAL};
            end
            3'b110: begin // c.beqz
                inst_o = {br_imm_hi, REG_ZERO, creg_hi, 3'b000, br_imm_lo, OPC_BRANCH};
            end
            default: begin // c.bnez
                inst_o = {br_imm_hi, REG_ZERO, creg_hi, 3'b001, br_imm_lo, OPC_BRANCH};
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/rvc_q0_expander.sv
`timescale 1ns/1ps
`default_nettype none

module rvc_q0_expander import rvc_pkg::*; (
    input  cinst_t cinst_i,
    output inst_t  inst_o
);

    logic [2:0]       funct3;
    logic [REG_W-1:0] creg_lo;     // rd' or rs2', bits 4:2
    logic [REG_W-1:0] creg_hi;     // rs1', bits 9:7
    logic [11:0]      addi4spn_imm;
    logic [11:0]      lw_imm;

    assign funct3  = cinst_i[15:13];
    assign creg_lo = {CREG_PREFIX, cinst_i[4:2]};
    assign creg_hi = {CREG_PREFIX, cinst_i[9:7]};

    // nzuimm[9:2] scaled by 4, zero extended
    assign addi4spn_imm = {2'b00, cinst_i[10:7], cinst_i[12:11], cinst_i[5], cinst_i[6],
                           2'b00};

    // word offset, bits 6:2 used
    assign lw_imm = {5'b00000, cinst_i[5], cinst_i[12:10], cinst_i[6], 2'b00};

    always_comb begin
        inst_o = NOP_INST;
        case (funct3)
            3'b000: begin // c.addi4spn
                inst_o = {addi4spn_imm, REG_SP, 3'b000, creg_lo, OPC_OP_IMM};
            end
            3'b010: begin // c.lw
                inst_o = {lw_imm, creg_hi, 3'b010, creg_lo, OPC_LOAD};
            end
            3'b110: begin
                // store splits the same offset across imm[11:5] and imm[4:0]
                inst_o = {lw_imm[11:5], creg_lo, creg_hi, 3'b010, lw_imm[4:0], OPC_STORE};
            end
            default: begin
                inst_o = NOP_INST; // reserved or unsupported in rv32i
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/rvc_pkg.sv
`default_nettype none

package rvc_pkg;

    localparam int CINST_W = 16; // compressed instruction
    localparam int INST_W  = 32; // expanded rv32i instruction
    localparam int REG_W   = 5;

    // rvc 3-bit register fields address x8..x15
    localparam logic [1:0] CREG_PREFIX = 2'b01;

    localparam logic [REG_W-1:0] REG_ZERO = 5'd0;
    localparam logic [REG_W-1:0] REG_RA   = 5'd1;
    localparam logic [REG_W-1:0] REG_SP   = 5'd2;

    typedef logic [CINST_W-1:0] cinst_t;
    typedef logic [INST_W-1:0]  inst_t;

    // quadrant field, bits 1:0 of the compressed word
    typedef enum logic [1:0] {
        Q0                = 2'b00,
        Q1                = 2'b01,
        Q2                = 2'b10,
        Q3_NOT_COMPRESSED = 2'b11
    } c_quadrant_e;

    // rv32i major opcodes produced by the expanders
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } base_opcode_e;

    // addi x0, x0, 0
    localparam inst_t NOP_INST    = {12'h000, REG_ZERO, 3'b000, REG_ZERO, OPC_OP_IMM};
    localparam inst_t EBREAK_INST = {12'h001, REG_ZERO, 3'b000, REG_ZERO, OPC_SYSTEM};

endpackage

`default_nettype wire
